// File: design/ex_arith.sv
/*
 * arithmetic results
 * add/sub with signed overflow flag, slt/sltu and clz/clo counts
 */
`timescale 1ns/1ps
`default_nettype none

module ex_arith (
    input  wire ex_pkg::alu_op_e op_i,
    input  wire ex_pkg::word_t   reg1_i,
    input  wire ex_pkg::word_t   reg2_i,
    output ex_pkg::word_t        res_o,
    output logic                 ovf_o
);
    import ex_pkg::*;

    word_t reg2_mux;
    word_t sum;
    word_t scan;
    logic  lt_s;
    logic  lt_u;
    cnt_t  cnt;

    // subtraction and signed compare go through the two's complement of reg2
    assign reg2_mux = (op_i inside {OP_SUB, OP_SUBU, OP_SLT}) ? ~reg2_i + 32'd1 : reg2_i;
    assign sum      = reg1_i + reg2_mux;

    // same sign in, other sign out
    assign ovf_o = (op_i inside {OP_ADD, OP_SUB}) &&
                   (reg1_i[31] == (reg2_i[31] ^ (op_i == OP_SUB))) &&
                   (sum[31] != reg1_i[31]);

    // differing signs decide directly, otherwise the difference sign does
    assign lt_s = (reg1_i[31] && !reg2_i[31]) ||
                  ((reg1_i[31] == reg2_i[31]) && sum[31]);
    assign lt_u = reg1_i < reg2_i;

    // clo counts leading zeros of the inverted word
    assign scan = (op_i == OP_CLO) ? ~reg1_i : reg1_i;

    always_comb begin
        logic found;
        cnt   = cnt_t'(32);   // all-zero scan word
        found = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (!found && scan[i]) begin
                cnt   = cnt_t'(31 - i);
                found = 1'b1;
            end
        end
    end

    always_comb begin
        case (op_i)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
                res_o = sum;
            end
            OP_SLT: begin
                res_o = {31'b0, lt_s};
            end
            OP_SLTU: begin
                res_o = {31'b0, lt_u};
            end
            OP_CLZ, OP_CLO: begin
                res_o = {26'b0, cnt};
            end
            default: begin
                res_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/ex_hilo.sv
/*
 * hi/lo register pair
 * loads the full 64-bit pair when written, cleared by reset
 */
`timescale 1ns/1ps
`default_nettype none

module ex_hilo (
    input  wire                 clk,
    input  wire                 arst_n_i,
    input  wire                 we_i,
    input  wire ex_pkg::dword_t hilo_i,
    output ex_pkg::word_t       hi_o,
    output ex_pkg::word_t       lo_o
);
    import ex_pkg::*;

    dword_t hilo_q;

    // mthi/mtlo come in with the other half already merged
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hilo_q <= '0;
        end else if (we_i) begin
            hilo_q <= hilo_i;
        end
    end

    assign hi_o = hilo_q[63:32];
    assign lo_o = hilo_q[31:0];

endmodule

`default_nettype wire

// File: design/ex_logic_shift.sv
/*
 * logic and shift results
 * or/and/nor/xor of both operands, shifts of reg2 by reg1[4:0]
 */
`timescale 1ns/1ps
`default_nettype none

module ex_logic_shift (
    input  wire ex_pkg::alu_op_e op_i,
    input  wire ex_pkg::word_t   reg1_i,
    input  wire ex_pkg::word_t   reg2_i,
    output ex_pkg::word_t        res_o
);
    import ex_pkg::*;

    shamt_t shamt;

    assign shamt = reg1_i[4:0]; // only the low five bits count

    always_comb begin
        case (op_i)
            OP_OR: begin
                res_o = reg1_i | reg2_i;
            end
            OP_AND: begin
                res_o = reg1_i & reg2_i;
            end
            OP_NOR: begin
                res_o = ~(reg1_i | reg2_i);
            end
            OP_XOR: begin
                res_o = reg1_i ^ reg2_i;
            end
            OP_SLL: begin
                res_o = reg2_i << shamt;
            end
            OP_SRL: begin
                res_o = reg2_i >> shamt;  // zero fill
            end
            OP_SRA: begin
                res_o = word_t'($signed(reg2_i) >>> shamt); // sign fill
            end
            default: begin
                res_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/ex_mult.sv
/*
 * multiplier and multiply-accumulate sequencer
 * product is combinational, madd/msub add hi/lo one cycle later
 */
`timescale 1ns/1ps
`default_nettype none

module ex_mult (
    input  wire                  clk,
    input  wire                  arst_n_i,
    input  wire                  start_i,
    input  wire ex_pkg::alu_op_e op_i,
    input  wire ex_pkg::word_t   reg1_i,
    input  wire ex_pkg::word_t   reg2_i,
    input  wire ex_pkg::dword_t  hilo_i,
    output ex_pkg::dword_t       prod_o,
    output logic                 acc_busy_o,
    output logic                 acc_we_o,
    output ex_pkg::dword_t       acc_o
);
    import ex_pkg::*;

    acc_state_e state_q;
    acc_state_e state_d;
    logic       sgn;
    logic       neg;
    word_t      opa;
    word_t      opb;
    dword_t     mag;
    dword_t     acc_q;   // product held for the add phase

    assign sgn = is_signed_mul(op_i);

    // multiply magnitudes, fix the sign afterwards
    assign opa = (sgn && reg1_i[31]) ? ~reg1_i + 32'd1 : reg1_i;
    assign opb = (sgn && reg2_i[31]) ? ~reg2_i + 32'd1 : reg2_i;
    assign mag = {32'b0, opa} * {32'b0, opb};
    assign neg = sgn && (reg1_i[31] ^ reg2_i[31]);

    assign prod_o = neg ? ~mag + 64'd1 : mag;

    always_comb begin
        case (state_q)
            ACC_IDLE: begin
                state_d = start_i ? ACC_ADD : ACC_IDLE;
            end
            default: begin
                state_d = ACC_IDLE;   // add phase lasts one cycle
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ACC_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            // msub subtracts, so store the negated product
            acc_q <= (op_i inside {OP_MSUB, OP_MSUBU}) ? ~prod_o + 64'd1 : prod_o;
        end
    end

    assign acc_busy_o = (state_q == ACC_ADD);
    assign acc_we_o   = (state_q == ACC_ADD);
    assign acc_o      = acc_q + hilo_i;

    // issue is stalled for the whole add phase
    a_no_start_in_add: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        state_q == ACC_ADD |-> !start_i
    );

endmodule

`default_nettype wire

// File: design/ex_pkg.sv
/*
 * execute unit shared definitions
 * word and pair types, the operation code, the accumulate phase
 * and small decode helpers used by the datapath and the testbench
 */
`default_nettype none

package ex_pkg;

    typedef logic [31:0] word_t;     // gpr value
    typedef logic [63:0] dword_t;    // product, hi/lo pair
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [5:0]  cnt_t;      // 0..32 leading bits

    typedef enum logic [4:0] {
        OP_NOP,
        OP_OR,
        OP_AND,
        OP_NOR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_CLZ,
        OP_CLO,
        OP_MUL,
        OP_MULT,
        OP_MULTU,
        OP_MADD,
        OP_MADDU,
        OP_MSUB,
        OP_MSUBU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } alu_op_e;

    // second phase of madd/msub adds the old hi/lo
    typedef enum logic {
        ACC_IDLE,
        ACC_ADD
    } acc_state_e;

    function automatic logic is_signed_mul(alu_op_e op);
        return op inside {OP_MUL, OP_MULT, OP_MADD, OP_MSUB};
    endfunction

    function automatic logic is_acc(alu_op_e op);
        return op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    endfunction

    // everything that ends up loading the hi/lo pair
    function automatic logic writes_hilo(alu_op_e op);
        return op inside {OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO,
                          OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    endfunction

endpackage

`default_nettype wire

// File: design/ex_unit.sv
/*
 * mips32 execute unit
 * valid/ready issue, one registered result per done pulse,
 * local hi/lo pair and a two-cycle multiply-accumulate path
 */
`timescale 1ns/1ps
`default_nettype none

module ex_unit (
    input  wire                     clk,
    input  wire                     arst_n_i,
    input  wire                     valid_i,
    output logic                    ready_o,
    input  wire ex_pkg::alu_op_e    op_i,
    input  wire ex_pkg::word_t      reg1_i,
    input  wire ex_pkg::word_t      reg2_i,
    input  wire ex_pkg::reg_addr_t  wd_i,
    input  wire                     wreg_i,
    output logic                    done_o,
    output ex_pkg::word_t           result_o,
    output ex_pkg::reg_addr_t       wd_o,
    output logic                    wreg_o,
    output ex_pkg::word_t           hi_o,
    output ex_pkg::word_t           lo_o
);
    import ex_pkg::*;

    logic      accept;
    logic      single;      // accepted op finishing this edge
    logic      acc_start;
    logic      acc_busy;
    logic      acc_we;
    logic      ar_ovf;
    logic      hilo_we;
    logic      done_q;
    logic      wreg_q;
    logic      acc_wreg_q;
    word_t     ls_res;
    word_t     ar_res;
    word_t     res_sel;
    word_t     result_q;
    dword_t    prod;
    dword_t    acc_sum;
    dword_t    hilo_wdata;
    reg_addr_t wd_q;
    reg_addr_t acc_wd_q;

    assign ready_o   = ~acc_busy;
    assign accept    = valid_i & ready_o;
    assign single    = accept & ~is_acc(op_i);
    assign acc_start = accept & is_acc(op_i);

    ex_logic_shift ex_logic_shift_inst (
        .op_i   (op_i),
        .reg1_i (reg1_i),
        .reg2_i (reg2_i),
        .res_o  (ls_res)
    );

    ex_arith ex_arith_inst (
        .op_i   (op_i),
        .reg1_i (reg1_i),
        .reg2_i (reg2_i),
        .res_o  (ar_res),
        .ovf_o  (ar_ovf)
    );

    ex_mult ex_mult_inst (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .start_i    (acc_start),
        .op_i       (op_i),
        .reg1_i     (reg1_i),
        .reg2_i     (reg2_i),
        .hilo_i     ({hi_o, lo_o}),
        .prod_o     (prod),
        .acc_busy_o (acc_busy),
        .acc_we_o   (acc_we),
        .acc_o      (acc_sum)
    );

    ex_hilo ex_hilo_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (hilo_we),
        .hilo_i   (hilo_wdata),
        .hi_o     (hi_o),
        .lo_o     (lo_o)
    );

    // result group follows from the op code
    always_comb begin
        case (op_i)
            OP_OR, OP_AND, OP_NOR, OP_XOR, OP_SLL, OP_SRL, OP_SRA: begin
                res_sel = ls_res;
            end
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO: begin
                res_sel = ar_res;
            end
            OP_MUL: begin
                res_sel = prod[31:0];   // low word only, hi/lo untouched
            end
            OP_MFHI: begin
                res_sel = hi_o;
            end
            OP_MFLO: begin
                res_sel = lo_o;
            end
            default: begin
                res_sel = '0;
            end
        endcase
    end

    // accumulate completion wins, no new op is accepted during it
    assign hilo_we = acc_we | (single & writes_hilo(op_i));

    always_comb begin
        if (acc_we) begin
            hilo_wdata = acc_sum;
        end else if (op_i == OP_MTHI) begin
            hilo_wdata = {reg1_i, lo_o};
        end else if (op_i == OP_MTLO) begin
            hilo_wdata = {hi_o, reg1_i};
        end else begin
            hilo_wdata = prod;  // mult/multu
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_q     <= 1'b0;
            wreg_q     <= 1'b0;
            acc_wreg_q <= 1'b0;
        end else begin
            done_q <= acc_we | single;
            if (acc_we) begin
                wreg_q <= acc_wreg_q;
            end else if (single) begin
                wreg_q <= wreg_i & ~ar_ovf; // overflowing add/sub drops the write
            end else begin
                wreg_q <= 1'b0;
            end
            if (acc_start) begin
                acc_wreg_q <= wreg_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_start) begin
            acc_wd_q <= wd_i;   // held until the add phase ends
        end
        if (acc_we) begin
            result_q <= '0;
            wd_q     <= acc_wd_q;
        end else if (single) begin
            result_q <= res_sel;
            wd_q     <= wd_i;
        end
    end

    assign done_o   = done_q;
    assign wreg_o   = wreg_q;
    assign wd_o     = wd_q;
    assign result_o = result_q;

    // completion and the accumulate stall never overlap
    a_done_ready: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        done_o |-> ready_o
    );

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the execute unit testbench with Verilator
# exit status is non-zero when the simulation log reports a failure

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f src.f --top-module tb_ex_unit \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_ex_unit 2>&1 | tee sim.log

grep -q "Regression failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Regression passed" sim.log \
    || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation PASSED"

// File: sim/ex_cases.txt
// op reg1 reg2 wd wreg, then expected result wreg hi lo
// all hex, op is the alu_op_e code, hi/lo are the values after done
// logic and shift
01 f0f00000 00000f0f 01 1 f0f00f0f 1 00000000 00000000
02 ffff0000 12345678 02 1 12340000 1 00000000 00000000
03 f0f0f0f0 0f0f0000 03 1 00000f0f 1 00000000 00000000
04 aaaa5555 ffff0000 04 1 55555555 1 00000000 00000000
05 00000004 000000ff 05 1 00000ff0 1 00000000 00000000
06 00000008 80000000 06 1 00800000 1 00000000 00000000
07 00000000 80000001 07 1 80000001 1 00000000 00000000
07 0000001f 80000001 08 1 ffffffff 1 00000000 00000000
07 00000024 f0000000 09 1 ff000000 1 00000000 00000000
// add and sub, overflow drops the write
08 7fffffff 00000001 0a 1 80000000 0 00000000 00000000
09 7fffffff 00000001 0b 1 80000000 1 00000000 00000000
0a 80000000 00000001 0c 1 7fffffff 0 00000000 00000000
0b 80000000 00000001 0d 1 7fffffff 1 00000000 00000000
08 00000005 fffffffd 0e 1 00000002 1 00000000 00000000
0a 00000003 00000005 0f 1 fffffffe 1 00000000 00000000
// compare and count
0c ffffffff 00000001 10 1 00000001 1 00000000 00000000
0d ffffffff 00000001 11 1 00000000 1 00000000 00000000
0d 00000001 ffffffff 12 1 00000001 1 00000000 00000000
0e 00000000 00000000 13 1 00000020 1 00000000 00000000
0e 00010000 00000000 14 1 0000000f 1 00000000 00000000
0f ffffffff 00000000 15 1 00000020 1 00000000 00000000
0f fff00000 00000000 16 1 0000000c 1 00000000 00000000
// multiply
11 fffffffe fffffffd 00 0 00000000 0 00000000 00000006
12 fffffffe fffffffd 00 0 00000000 0 fffffffb 00000006
10 fffffff9 00000006 17 1 ffffffd6 1 fffffffb 00000006
// accumulate on top of a fresh mult
11 00010000 00010000 00 0 00000000 0 00000001 00000000
13 fffffffe 00000003 18 1 00000000 1 00000000 fffffffa
15 00000004 00000005 19 0 00000000 0 00000000 ffffffe6
14 ffffffff 00000002 1a 0 00000000 0 00000002 ffffffe4
16 00000003 00000001 1b 0 00000000 0 00000002 ffffffe1
// hi/lo moves
19 cafe0001 00000000 00 0 00000000 0 cafe0001 ffffffe1
1a 0badf00d 00000000 00 0 00000000 0 cafe0001 0badf00d
17 00000000 00000000 1c 1 cafe0001 1 cafe0001 0badf00d
18 00000000 00000000 1d 1 0badf00d 1 cafe0001 0badf00d

// File: sim/tb_ex_unit.sv
/*
 * testbench for the execute unit
 * replays the case file through the valid/ready issue handshake and
 * checks result, write flag, destination, hi/lo and handshake timing
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_unit;
    import ex_pkg::*;

    localparam int NUM_CASES      = 34;
    localparam int FIELDS         = 9;    // words per case line
    localparam int TIMEOUT_CYCLES = NUM_CASES * 4 + 50;

    logic      clk;
    logic      arst_n_i;
    logic      valid_i;
    logic      ready_o;
    alu_op_e   op_i;
    word_t     reg1_i;
    word_t     reg2_i;
    reg_addr_t wd_i;
    logic      wreg_i;
    logic      done_o;
    word_t     result_o;
    reg_addr_t wd_o;
    logic      wreg_o;
    word_t     hi_o;
    word_t     lo_o;

    logic [31:0] case_mem [0:NUM_CASES*FIELDS-1];
    integer      seed      = 32'h8233;
    int          cycle_cnt = 0;
    int          case_idx  = 0;    // shown in error lines

    ex_unit ex_unit_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .ready_o  (ready_o),
        .op_i     (op_i),
        .reg1_i   (reg1_i),
        .reg2_i   (reg2_i),
        .wd_i     (wd_i),
        .wreg_i   (wreg_i),
        .done_o   (done_o),
        .result_o (result_o),
        .wd_o     (wd_o),
        .wreg_o   (wreg_o),
        .hi_o     (hi_o),
        .lo_o     (lo_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;    // 4 ns period
    end

    // watchdog over the whole run
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $fatal(1, "watchdog expired");
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s in case %0d: got 0x%0h, expected 0x%0h",
                     name, case_idx, actual, expected);
            $display("Regression failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // madd/msub family needs an extra add phase
    function automatic int expected_latency(alu_op_e op);
        if (op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU}) begin
            return 2;
        end
        return 1;
    endfunction

    // hold reset for 4 cycles, state must be cleared before release
    task automatic apply_reset();
        arst_n_i = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        check_value("hi_o", 64'(hi_o), 64'd0);
        check_value("lo_o", 64'(lo_o), 64'd0);
        check_value("done_o", 64'(done_o), 64'd0);
        check_value("wreg_o", 64'(wreg_o), 64'd0);
        check_value("ready_o", 64'(ready_o), 64'd1);
        arst_n_i = 1'b1;
    endtask

    task automatic run_case(input int idx);
        int      base;
        int      lat;
        int      exp_lat;
        int      idle;
        alu_op_e op;
        base    = idx * FIELDS;
        op      = alu_op_e'(case_mem[base][4:0]);
        exp_lat = expected_latency(op);
        idle    = 0;
        if (exp_lat == 1) begin
            idle = {$random(seed)} % 3;   // gaps between single-cycle ops
        end

        // done_o is a single pulse, so it stays low while idle
        repeat (idle) begin
            @(posedge clk);
            #1;
            check_value("done_o", 64'(done_o), 64'd0);
        end

        valid_i = 1'b1;
        op_i    = op;
        reg1_i  = case_mem[base + 1];
        reg2_i  = case_mem[base + 2];
        wd_i    = case_mem[base + 3][4:0];
        wreg_i  = case_mem[base + 4][0];
        check_value("ready_o", 64'(ready_o), 64'd1);

        // first edge accepts, then follow the op until done
        lat = 0;
        do begin
            @(posedge clk);
            #1;
            valid_i = 1'b0;
            lat++;
            check_value("ready_o", 64'(ready_o), (exp_lat == 2 && lat == 1) ? 64'd0 : 64'd1);
        end while (done_o !== 1'b1);

        check_value("latency", 64'(lat), 64'(exp_lat));
        check_value("result_o", 64'(result_o), 64'(case_mem[base + 5]));
        check_value("wreg_o", 64'(wreg_o), 64'(case_mem[base + 6][0]));
        check_value("wd_o", 64'(wd_o), 64'(case_mem[base + 3][4:0]));
        check_value("hi_o", 64'(hi_o), 64'(case_mem[base + 7]));
        check_value("lo_o", 64'(lo_o), 64'(case_mem[base + 8]));
    endtask

    initial begin
        arst_n_i = 1'b0;
        valid_i  = 1'b0;
        op_i     = OP_NOP;
        reg1_i   = '0;
        reg2_i   = '0;
        wd_i     = '0;
        wreg_i   = 1'b0;

        $readmemh("sim/ex_cases.txt", case_mem);
        if ($isunknown(case_mem[NUM_CASES*FIELDS-1])) begin
            $display("The case file is missing or holds fewer than %0d cases", NUM_CASES);
            $display("Regression failed");
            $fatal(1, "no stimulus");
        end

        apply_reset();

        for (int i = 0; i < NUM_CASES; i++) begin
            case_idx = i;
            run_case(i);
        end

        // hi/lo end up non-zero, a second reset has to clear them
        case_idx = NUM_CASES;
        apply_reset();

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
design/ex_pkg.sv
design/ex_logic_shift.sv
design/ex_arith.sv
design/ex_mult.sv
design/ex_hilo.sv
design/ex_unit.sv
sim/tb_ex_unit.sv
